//--- all.f
comp_pkg.sv
lowest_set_bit.sv
comp_regs.sv
noc_tx.sv
noc_rx.sv
comp_manager.sv
comp_props.sv
tb_comp_manager.sv

//--- Makefile
# Verilator build for the component manager testbench

VERILATOR ?= verilator
TOP       ?= tb_comp_manager
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_comp_manager.sv
`timescale 1ns/1ps

module tb_comp_manager;
    import comp_pkg::*;

    localparam int max_cycles = 3000;  // about five times the full run

    // buffer settings exactly as written over the bus
    typedef struct packed {
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] loc;
        logic [31:0] msg_type;
        logic [31:0] inst;
        logic [31:0] tid;
        logic [31:0] data;
    } buf_set_t;

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    logic                 wb_cyc_i;
    logic                 wb_stb_i;
    logic                 wb_we_i;
    logic [wb_addr_w-1:0] wb_adr_i;
    logic [3:0]           wb_sel_i;
    logic [wb_data_w-1:0] wb_dat_i;
    logic [wb_data_w-1:0] wb_dat_o;
    logic                 wb_ack_o;
    noc_flit_t            noc_din_o;
    noc_flit_t            noc_dout_i;
    logic                 noc_wr_o;
    logic                 noc_rd_o;
    logic                 noc_wait_i;
    logic                 noc_nd_i;

    buf_set_t  model [buffer_size];
    noc_flit_t exp_q [$];  // flits the sink should see in order
    noc_flit_t src_q [$];  // flits waiting to be offered to the DUT
    integer    seed = 32'h90f4_4464;
    int        rnd;
    logic      sink_stall = 1'b0;
    int        wr_count = 0;
    int        pop_count = 0;
    int        cycle_count = 0;
    int        check_count = 0;
    int        error_count = 0;

    comp_manager dut_i (.*);

    bind comp_regs comp_props u_props (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .pulse_i (wb_ack_o),
        .req_i   (tx_req_o),
        .busy_i  (tx_busy_i)
    );

    bind noc_tx comp_props u_props (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .pulse_i (noc_wr_o),
        .req_i   (tx_req_i),
        .busy_i  (tx_busy_o)
    );

    always #2 clk_i = ~clk_i;

    //////////////////////////////
    // reference and helpers
    //////////////////////////////
    function automatic noc_flit_t build_flit(input buf_set_t s);
        noc_flit_t f;
        f.src.x           = soc_size_x'(noc_x);  // own node is the source
        f.src.y           = soc_size_y'(noc_y);
        f.src.loc         = local_w'(noc_local);
        f.dst.x           = s.x[soc_size_x-1:0];
        f.dst.y           = s.y[soc_size_y-1:0];
        f.dst.loc         = s.loc[local_w-1:0];
        f.msg.type_id     = s.tid[7:0];
        f.msg.instance_id = s.inst[7:0];
        f.msg.msg_type    = {5'b0, s.msg_type[2:0]};  // only 3 bits are stored
        f.msg.payload     = s.data;
        return f;
    endfunction

    function automatic noc_flit_t make_rx_flit(input logic [7:0] inst, input logic [7:0] tid,
                                               input logic [7:0] mt, input logic [31:0] pl);
        noc_flit_t f;
        f.src.x           = 1'b1;  // some remote node
        f.src.y           = 1'b1;
        f.src.loc         = 3'd6;
        f.dst.x           = soc_size_x'(noc_x);
        f.dst.y           = soc_size_y'(noc_y);
        f.dst.loc         = local_w'(noc_local);
        f.msg.type_id     = tid;
        f.msg.instance_id = inst;
        f.msg.msg_type    = mt;
        f.msg.payload     = pl;
        return f;
    endfunction

    function automatic logic [7:0] ctrl_addr(input logic [6:0] sel);
        return {1'b0, sel};
    endfunction

    function automatic logic [7:0] buf_addr(input logic [3:0] breg, input int b);
        return {1'b1, breg, b[2:0]};
    endfunction

    task automatic check(input logic [noc_bus_w-1:0] got, input logic [noc_bus_w-1:0] exp,
                         input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        @(negedge clk_i);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!wb_ack_o && n < 16);
        if (!wb_ack_o) begin
            error_count++;
            $display("bus cycle to address %h was never acknowledged", adr);
        end
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        bus_cycle(1'b1, adr, dat, ignored);
    endtask

    task automatic read_check(input logic [7:0] adr, input logic [31:0] exp, input string what);
        logic [31:0] rd;
        bus_cycle(1'b0, adr, 32'h0, rd);
        check(noc_bus_w'(rd), noc_bus_w'(exp), what);
    endtask

    // poll a register until it shows the value and then check it
    task automatic wait_reg(input logic [7:0] adr, input logic [31:0] exp, input string what);
        logic [31:0] rd;
        int n;
        n = 0;
        bus_cycle(1'b0, adr, 32'h0, rd);
        while (rd !== exp && n < 100) begin
            bus_cycle(1'b0, adr, 32'h0, rd);
            n++;
        end
        check(noc_bus_w'(rd), noc_bus_w'(exp), what);
    endtask

    task automatic wait_writes(input int target);
        int n;
        n = 0;
        while (wr_count < target && n < 300) begin
            @(negedge clk_i);
            n++;
        end
        if (wr_count < target) begin
            error_count++;
            $display("only %0d of %0d flits reached the sink", wr_count, target);
        end
    endtask

    task automatic wait_pops(input int target);
        int n;
        n = 0;
        while (pop_count < target && n < 300) begin
            @(negedge clk_i);
            n++;
        end
        if (pop_count < target) begin
            error_count++;
            $display("the DUT never popped the offered flit");
        end
    endtask

    task automatic configure_buffer(input int b, input buf_set_t s);
        bus_write(buf_addr(breg_phy_x, b), s.x);
        bus_write(buf_addr(breg_phy_y, b), s.y);
        bus_write(buf_addr(breg_phy_local, b), s.loc);
        bus_write(buf_addr(breg_msg_type, b), s.msg_type);
        bus_write(buf_addr(breg_instance_id, b), s.inst);
        bus_write(buf_addr(breg_type_id, b), s.tid);
        bus_write(buf_addr(breg_data, b), s.data);
        model[b] = s;
    endtask

    //////////////////////////////
    // noc sink and source
    //////////////////////////////
    initial begin
        noc_wait_i = 1'b1;
        forever begin
            @(negedge clk_i);
            rnd = $random(seed);
            noc_wait_i = sink_stall | rnd[0];  // stalls about half the cycles
        end
    end

    // holds each flit until the DUT pops it
    initial begin
        noc_nd_i   = 1'b0;
        noc_dout_i = '0;
        forever begin
            @(negedge clk_i);
            if (noc_nd_i && noc_rd_o) begin
                noc_nd_i = 1'b0;
                pop_count++;
            end else if (!noc_nd_i && src_q.size() > 0) begin
                noc_dout_i = src_q.pop_front();
                noc_nd_i   = 1'b1;
            end
        end
    end

    always @(negedge clk_i) begin
        if (!rst_i && noc_wr_o) begin
            wr_count++;
            if (exp_q.size() == 0) begin
                error_count++;
                $display("a flit was sent at %0t ns while none was expected", $time);
            end else begin
                check(noc_din_o, exp_q.pop_front(), "sent flit");
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, the test did not finish", cycle_count);
            $display("checks run: %0d, errors: %0d", check_count, error_count + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        buf_set_t    s;
        logic [31:0] exp_res;
        int          pops_before;
        int          total;
        rst_i    = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = 4'hf;
        wb_dat_i = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // info and idle registers
        read_check(ctrl_addr(reg_info_x), 32'h0, "info x");
        read_check(ctrl_addr(reg_info_y), 32'h0, "info y");
        read_check(ctrl_addr(reg_info_local), 32'h0, "info local");
        read_check(ctrl_addr(reg_info_buffer_size), 32'h4, "info buffer size");
        read_check(ctrl_addr(reg_cmd_idle), 32'h1, "command idle");

        // ids match buffer 0 but nothing is allocated yet
        bus_write(buf_addr(breg_instance_id, 0), 32'h77);
        bus_write(buf_addr(breg_type_id, 0), 32'h78);
        pops_before = pop_count;
        src_q.push_back(make_rx_flit(8'h77, 8'h78, 8'h01, 32'h0bad_0bad));
        wait_pops(pops_before + 1);
        read_check(buf_addr(breg_rx, 0), 32'h0, "rx valid on unallocated buffer");

        // allocation until the buffers run out
        for (int i = 0; i < 5; i++) begin
            bus_write(ctrl_addr(reg_cmd), 32'h0);
            exp_res = (i < 4) ? 32'(i) : 32'hffff_ffff;
            read_check(ctrl_addr(reg_cmd_result), exp_res, "allocation result");
        end

        // buffer fields, masked on readback
        s = '{32'h1, 32'h0, 32'h3, 32'h2, 32'h10, 32'h20, 32'h1111_0000};
        configure_buffer(0, s);
        s = '{32'hffff_ffff, 32'h6, 32'h1d, 32'h0b, 32'h1234, 32'habc, 32'hcafe_0001};
        configure_buffer(1, s);
        s = '{32'h0, 32'h1, 32'h7, 32'h4, 32'h41, 32'h42, 32'h2222_2222};
        configure_buffer(2, s);
        s = '{32'h2, 32'h3, 32'h0, 32'h1, 32'h55, 32'h66, 32'h3333_3333};
        configure_buffer(3, s);
        for (int b = 0; b < buffer_size; b++) begin
            read_check(buf_addr(breg_phy_x, b), model[b].x & 32'h1, $sformatf("phy x %0d", b));
            read_check(buf_addr(breg_phy_y, b), model[b].y & 32'h1, $sformatf("phy y %0d", b));
            read_check(buf_addr(breg_phy_local, b), model[b].loc & 32'h7,
                       $sformatf("phy local %0d", b));
            read_check(buf_addr(breg_instance_id, b), model[b].inst & 32'hff,
                       $sformatf("instance id %0d", b));
            read_check(buf_addr(breg_type_id, b), model[b].tid & 32'hff,
                       $sformatf("type id %0d", b));
        end
        read_check(ctrl_addr(7'd3), 32'h0, "unmapped control register");
        read_check(buf_addr(4'd9, 1), 32'h0, "unmapped buffer register");
        bus_write(buf_addr(breg_phy_local, 5), 32'h0);  // slot 5 does not exist
        read_check(buf_addr(breg_phy_local, 5), 32'h0, "unmapped buffer slot");
        read_check(buf_addr(breg_phy_local, 1), 32'h5, "buffer 1 after slot 5 write");
        bus_write(ctrl_addr(reg_info_buffer_size), 32'h55);
        read_check(ctrl_addr(reg_info_buffer_size), 32'h4, "read-only register");

        // single send under random wait
        exp_q.push_back(build_flit(model[2]));
        bus_write(buf_addr(breg_tx, 2), 32'h1);
        read_check(buf_addr(breg_tx, 2), 32'h1, "tx pending");
        wait_writes(1);
        wait_reg(buf_addr(breg_tx, 2), 32'h0, "tx cleared");

        // buffer 1 blocks the sink while 3 and 0 queue up
        sink_stall = 1'b1;
        exp_q.push_back(build_flit(model[1]));
        exp_q.push_back(build_flit(model[0]));
        exp_q.push_back(build_flit(model[3]));
        bus_write(buf_addr(breg_tx, 1), 32'h1);
        bus_write(buf_addr(breg_tx, 3), 32'h1);
        bus_write(buf_addr(breg_tx, 0), 32'h1);
        bus_write(buf_addr(breg_tx, 3), 32'h1);  // refused while still pending
        read_check(buf_addr(breg_tx, 3), 32'h1, "tx pending 3");
        read_check(buf_addr(breg_tx, 0), 32'h1, "tx pending 0");
        sink_stall = 1'b0;
        wait_writes(4);
        repeat (30) @(negedge clk_i);
        check(noc_bus_w'(wr_count), noc_bus_w'(4), "number of sent flits");

        // receive into buffer 1 and hold back the next flit
        src_q.push_back(make_rx_flit(8'h34, 8'hbc, 8'h0b, 32'hdead_beef));
        wait_reg(buf_addr(breg_rx, 1), 32'h1, "rx valid first flit");
        read_check(buf_addr(breg_data, 1), 32'hdead_beef, "rx data first flit");
        read_check(buf_addr(breg_msg_type, 1), 32'h3, "rx type first flit");
        read_check(buf_addr(breg_rx, 0), 32'h0, "rx valid other buffer");
        pops_before = pop_count;
        src_q.push_back(make_rx_flit(8'h34, 8'hbc, 8'h0c, 32'h0123_4567));
        repeat (20) @(negedge clk_i);
        check(noc_bus_w'(pop_count), noc_bus_w'(pops_before), "held flit was popped");
        bus_write(buf_addr(breg_rx, 1), 32'h0);
        wait_pops(pops_before + 1);
        wait_reg(buf_addr(breg_rx, 1), 32'h1, "rx valid second flit");
        read_check(buf_addr(breg_data, 1), 32'h0123_4567, "rx data second flit");
        read_check(buf_addr(breg_msg_type, 1), 32'h4, "rx type second flit");
        bus_write(buf_addr(breg_rx, 1), 32'h0);
        read_check(buf_addr(breg_rx, 1), 32'h0, "rx valid after ack");

        // flit with no owner is dropped
        pops_before = pop_count;
        src_q.push_back(make_rx_flit(8'hee, 8'hee, 8'h02, 32'h5555_aaaa));
        wait_pops(pops_before + 1);
        repeat (5) @(negedge clk_i);
        for (int b = 0; b < buffer_size; b++) begin
            read_check(buf_addr(breg_rx, b), 32'h0, $sformatf("rx valid %0d after drop", b));
        end

        repeat (10) @(negedge clk_i);
        check(noc_bus_w'(exp_q.size()), '0, "flits still expected");
        total = error_count + dut_i.u_regs.u_props.fail_count + dut_i.u_tx.u_props.fail_count;
        $display("checks run: %0d, errors: %0d", check_count, total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- comp_props.sv
`timescale 1ns/1ps

module comp_props (
    input logic                             clk_i,
    input logic                             rst_i,
    input logic                             pulse_i,  // strobe that must drop after one cycle
    input logic [comp_pkg::buffer_size-1:0] req_i,
    input logic [comp_pkg::buffer_size-1:0] busy_i
);

    int fail_count = 0;  // read by the testbench at the end

    //////////////////////////////
    // strobe rules
    //////////////////////////////
    single_pulse: assert property (@(posedge clk_i) disable iff (rst_i) pulse_i |=> !pulse_i)
        else begin
            fail_count++;
            $error("strobe stayed high for two cycles");
        end

    // a pending buffer never gets a second request
    req_not_busy: assert property (@(posedge clk_i) disable iff (rst_i) (req_i & busy_i) == '0)
        else begin
            fail_count++;
            $error("send request raised for a buffer that is still pending");
        end

endmodule

//--- comp_manager.sv
`timescale 1ns/1ps

module comp_manager (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic [comp_pkg::wb_addr_w-1:0] wb_adr_i,
    input  logic [3:0]                     wb_sel_i,
    input  logic                           wb_we_i,
    input  logic [comp_pkg::wb_data_w-1:0] wb_dat_i,
    output logic [comp_pkg::wb_data_w-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    output comp_pkg::noc_flit_t            noc_din_o,
    output logic                           noc_wr_o,
    output logic                           noc_rd_o,
    input  comp_pkg::noc_flit_t            noc_dout_i,
    input  logic                           noc_wait_i,
    input  logic                           noc_nd_i
);
    import comp_pkg::*;

    buf_cfg_arr_t           buf_cfg;
    buf_rx_arr_t            rx_buf;
    logic [buffer_size-1:0] alloc_used;
    logic [buffer_size-1:0] tx_req;
    logic [buffer_size-1:0] tx_busy;
    logic [buffer_size-1:0] rx_ack;
    logic [buffer_size-1:0] rx_valid;

    comp_regs u_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_adr_i     (wb_adr_i),
        .wb_sel_i     (wb_sel_i),
        .wb_we_i      (wb_we_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .buf_cfg_o    (buf_cfg),
        .alloc_used_o (alloc_used),
        .tx_req_o     (tx_req),
        .rx_ack_o     (rx_ack),
        .tx_busy_i    (tx_busy),
        .rx_valid_i   (rx_valid),
        .rx_buf_i     (rx_buf)
    );

    noc_tx u_tx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .buf_cfg_i  (buf_cfg),
        .tx_req_i   (tx_req),
        .tx_busy_o  (tx_busy),
        .noc_wait_i (noc_wait_i),
        .noc_wr_o   (noc_wr_o),
        .noc_din_o  (noc_din_o)
    );

    noc_rx u_rx (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .buf_cfg_i    (buf_cfg),
        .alloc_used_i (alloc_used),
        .rx_ack_i     (rx_ack),
        .rx_valid_o   (rx_valid),
        .rx_buf_o     (rx_buf),
        .noc_dout_i   (noc_dout_i),
        .noc_nd_i     (noc_nd_i),
        .noc_rd_o     (noc_rd_o)
    );

endmodule

//--- noc_rx.sv
`timescale 1ns/1ps

module noc_rx (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  comp_pkg::buf_cfg_arr_t           buf_cfg_i,
    input  logic [comp_pkg::buffer_size-1:0] alloc_used_i,
    input  logic [comp_pkg::buffer_size-1:0] rx_ack_i,
    output logic [comp_pkg::buffer_size-1:0] rx_valid_o,
    output comp_pkg::buf_rx_arr_t            rx_buf_o,
    input  comp_pkg::noc_flit_t              noc_dout_i,
    input  logic                             noc_nd_i,
    output logic                             noc_rd_o
);
    import comp_pkg::*;

    typedef enum logic [1:0] {
        rx_settle,  // one idle cycle after each pop
        rx_idle,
        rx_scan,
        rx_hold
    } rx_state_t;

    rx_state_t               state;
    logic [buffer_idx_w-1:0] idx;
    logic                    match;
    logic                    slot_free;
    logic                    store;

    // allocated buffer with the same ids as the flit
    assign match = alloc_used_i[idx]
                && buf_cfg_i[idx].instance_id == noc_dout_i.msg.instance_id
                && buf_cfg_i[idx].type_id == noc_dout_i.msg.type_id;

    assign slot_free = ~rx_valid_o[idx] | rx_ack_i[idx];
    assign store     = (state == rx_hold) && slot_free;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state      <= rx_settle;
            idx        <= '0;
            rx_valid_o <= '0;
            noc_rd_o   <= 1'b1;  // flush whatever sits at the port
        end else begin
            noc_rd_o   <= 1'b0;
            rx_valid_o <= rx_valid_o & ~rx_ack_i;
            case (state)
                rx_settle: state <= rx_idle;
                rx_idle: begin
                    if (noc_nd_i) begin
                        state <= rx_scan;
                    end
                end
                rx_scan: begin
                    if (match) begin
                        state <= rx_hold;
                    end else if (idx == buffer_idx_w'(buffer_size - 1)) begin
                        idx      <= '0;  // no owner, drop it
                        noc_rd_o <= 1'b1;
                        state    <= rx_settle;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                rx_hold: begin
                    if (slot_free) begin
                        rx_valid_o[idx] <= 1'b1;
                        idx             <= '0;
                        noc_rd_o        <= 1'b1;
                        state           <= rx_settle;
                    end
                end
                default: state <= rx_settle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (store) begin
            rx_buf_o[idx].msg_type <= noc_dout_i.msg.msg_type[2:0];
            rx_buf_o[idx].data     <= noc_dout_i.msg.payload;
        end
    end

endmodule

//--- noc_tx.sv
`timescale 1ns/1ps

module noc_tx (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  comp_pkg::buf_cfg_arr_t           buf_cfg_i,
    input  logic [comp_pkg::buffer_size-1:0] tx_req_i,
    output logic [comp_pkg::buffer_size-1:0] tx_busy_o,
    input  logic                             noc_wait_i,
    output logic                             noc_wr_o,
    output comp_pkg::noc_flit_t              noc_din_o
);
    import comp_pkg::*;

    typedef enum logic [1:0] {
        tx_search,
        tx_load,
        tx_send
    } tx_state_t;

    tx_state_t               state;
    logic                    hit;
    logic [buffer_idx_w-1:0] found_idx;
    logic [buffer_idx_w-1:0] sel_idx;
    noc_flit_t               flit;

    assign noc_din_o = flit;

    lowest_set_bit u_busy_search (
        .vec_i (tx_busy_o),
        .hit_o (hit),
        .idx_o (found_idx)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state     <= tx_search;
            tx_busy_o <= '0;
            sel_idx   <= '0;
            noc_wr_o  <= 1'b0;
        end else begin
            noc_wr_o  <= 1'b0;
            tx_busy_o <= tx_busy_o | tx_req_i;
            case (state)
                tx_search: begin
                    if (hit) begin
                        sel_idx <= found_idx;
                        state   <= tx_load;
                    end
                end
                tx_load: begin
                    tx_busy_o[sel_idx] <= 1'b0;  // buffer may be rewritten now
                    state              <= tx_send;
                end
                tx_send: begin
                    if (!noc_wait_i) begin
                        noc_wr_o <= 1'b1;
                        state    <= tx_search;
                    end
                end
                default: state <= tx_search;
            endcase
        end
    end

    // flit is held from load until the write pulse
    always_ff @(posedge clk_i) begin
        if (state == tx_load) begin
            flit.src.x           <= soc_size_x'(noc_x);
            flit.src.y           <= soc_size_y'(noc_y);
            flit.src.loc         <= local_w'(noc_local);
            flit.dst             <= buf_cfg_i[sel_idx].dst;
            flit.msg.type_id     <= buf_cfg_i[sel_idx].type_id;
            flit.msg.instance_id <= buf_cfg_i[sel_idx].instance_id;
            flit.msg.msg_type    <= 8'(buf_cfg_i[sel_idx].msg_type);
            flit.msg.payload     <= buf_cfg_i[sel_idx].data;
        end
    end

endmodule

//--- comp_regs.sv
`timescale 1ns/1ps

module comp_regs (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  comp_pkg::wb_addr_u              wb_adr_i,
    input  logic [3:0]                      wb_sel_i,
    input  logic                            wb_we_i,
    input  logic [comp_pkg::wb_data_w-1:0]  wb_dat_i,
    output logic [comp_pkg::wb_data_w-1:0]  wb_dat_o,
    output logic                            wb_ack_o,
    output comp_pkg::buf_cfg_arr_t          buf_cfg_o,
    output logic [comp_pkg::buffer_size-1:0] alloc_used_o,
    output logic [comp_pkg::buffer_size-1:0] tx_req_o,
    output logic [comp_pkg::buffer_size-1:0] rx_ack_o,
    input  logic [comp_pkg::buffer_size-1:0] tx_busy_i,
    input  logic [comp_pkg::buffer_size-1:0] rx_valid_i,
    input  comp_pkg::buf_rx_arr_t           rx_buf_i
);
    import comp_pkg::*;

    logic [buffer_size-1:0]  alloc_free;
    logic [wb_data_w-1:0]    cmd_result;
    buf_cfg_arr_t            cfg;
    logic                    free_hit;
    logic [buffer_idx_w-1:0] free_idx;
    logic                    accept;
    logic                    is_ctrl;
    logic                    buf_ok;
    logic [buffer_idx_w-1:0] bidx;
    logic [wb_data_w-1:0]    rd_data;

    assign accept  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign is_ctrl = (wb_adr_i.ctrl.space == space_ctrl);
    assign buf_ok  = (wb_adr_i.bufr.buf_sel < buffer_size);  // upper slots unmapped
    assign bidx    = wb_adr_i.bufr.buf_sel[buffer_idx_w-1:0];

    assign buf_cfg_o    = cfg;
    assign alloc_used_o = ~alloc_free;

    lowest_set_bit u_free_search (
        .vec_i (alloc_free),
        .hit_o (free_hit),
        .idx_o (free_idx)
    );

    //////////////////////////////
    // read mux
    //////////////////////////////
    always_comb begin
        rd_data = '0;
        if (is_ctrl) begin
            case (wb_adr_i.ctrl.ctrl_sel)
                reg_cmd_result:       rd_data = cmd_result;
                reg_cmd_idle:         rd_data = wb_data_w'(1);  // allocation is single cycle
                reg_info_x:           rd_data = wb_data_w'(noc_x);
                reg_info_y:           rd_data = wb_data_w'(noc_y);
                reg_info_local:       rd_data = wb_data_w'(noc_local);
                reg_info_buffer_size: rd_data = wb_data_w'(buffer_size);
                default:              rd_data = '0;
            endcase
        end else if (buf_ok) begin
            case (wb_adr_i.bufr.breg)
                breg_phy_x:       rd_data = wb_data_w'(cfg[bidx].dst.x);
                breg_phy_y:       rd_data = wb_data_w'(cfg[bidx].dst.y);
                breg_phy_local:   rd_data = wb_data_w'(cfg[bidx].dst.loc);
                breg_msg_type:    rd_data = wb_data_w'(rx_buf_i[bidx].msg_type);
                breg_instance_id: rd_data = wb_data_w'(cfg[bidx].instance_id);
                breg_type_id:     rd_data = wb_data_w'(cfg[bidx].type_id);
                breg_data:        rd_data = rx_buf_i[bidx].data;
                breg_tx:          rd_data = wb_data_w'(tx_busy_i[bidx]);
                breg_rx:          rd_data = wb_data_w'(rx_valid_i[bidx]);
                default:          rd_data = '0;
            endcase
        end
    end

    //////////////////////////////
    // buffer configuration
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (accept && wb_we_i && !is_ctrl && buf_ok) begin
            case (wb_adr_i.bufr.breg)
                breg_phy_x:       cfg[bidx].dst.x       <= wb_dat_i[soc_size_x-1:0];
                breg_phy_y:       cfg[bidx].dst.y       <= wb_dat_i[soc_size_y-1:0];
                breg_phy_local:   cfg[bidx].dst.loc     <= wb_dat_i[local_w-1:0];
                breg_msg_type:    cfg[bidx].msg_type    <= wb_dat_i[2:0];
                breg_instance_id: cfg[bidx].instance_id <= wb_dat_i[7:0];
                breg_type_id:     cfg[bidx].type_id     <= wb_dat_i[7:0];
                breg_data:        cfg[bidx].data        <= wb_dat_i;
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // bus handshake and commands
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_ack_o   <= 1'b0;
            wb_dat_o   <= '0;
            tx_req_o   <= '0;
            rx_ack_o   <= '0;
            alloc_free <= '1;
            cmd_result <= '0;
        end else begin
            wb_ack_o <= accept;
            tx_req_o <= '0;  // strobes last one cycle
            rx_ack_o <= '0;
            if (accept) begin
                wb_dat_o <= rd_data;
                if (wb_we_i && is_ctrl && wb_adr_i.ctrl.ctrl_sel == reg_cmd) begin
                    if (free_hit) begin
                        alloc_free[free_idx] <= 1'b0;
                        cmd_result           <= wb_data_w'(free_idx);
                    end else begin
                        cmd_result <= cmd_result_err;
                    end
                end
                if (wb_we_i && !is_ctrl && buf_ok) begin
                    // a pending send refuses a new request
                    if (wb_adr_i.bufr.breg == breg_tx && !tx_busy_i[bidx]) begin
                        tx_req_o[bidx] <= wb_dat_i[0];
                    end
                    if (wb_adr_i.bufr.breg == breg_rx && rx_valid_i[bidx]) begin
                        rx_ack_o[bidx] <= ~wb_dat_i[0];  // writing 0 frees the slot
                    end
                end
            end
        end
    end

endmodule

//--- lowest_set_bit.sv
`timescale 1ns/1ps

module lowest_set_bit (
    input  logic [comp_pkg::buffer_size-1:0]  vec_i,
    output logic                              hit_o,
    output logic [comp_pkg::buffer_idx_w-1:0] idx_o
);
    import comp_pkg::*;

    // walk down so the lowest set bit wins
    always_comb begin
        hit_o = |vec_i;
        idx_o = '0;
        for (int i = buffer_size - 1; i >= 0; i--) begin
            if (vec_i[i]) begin
                idx_o = i[buffer_idx_w-1:0];
            end
        end
    end

endmodule

//--- comp_pkg.sv
package comp_pkg;

    //////////////////////////////
    // bus and noc geometry
    //////////////////////////////
    localparam int wb_addr_w = 8;
    localparam int wb_data_w = 32;

    localparam int soc_size_x = 1;   // coordinate widths
    localparam int soc_size_y = 1;
    localparam int local_w    = 3;

    localparam int noc_x     = 0;    // own node
    localparam int noc_y     = 0;
    localparam int noc_local = 0;

    localparam int buffer_size  = 4;
    localparam int buffer_idx_w = 2;

    localparam int noc_data_w = 56;
    localparam int noc_bus_w  = 66;

    //////////////////////////////
    // register map
    //////////////////////////////
    localparam logic space_ctrl = 1'b0;
    localparam logic space_buf  = 1'b1;

    localparam logic [6:0] reg_cmd              = 7'd0;
    localparam logic [6:0] reg_cmd_result       = 7'd1;
    localparam logic [6:0] reg_cmd_idle         = 7'd2;
    localparam logic [6:0] reg_info_x           = 7'd5;
    localparam logic [6:0] reg_info_y           = 7'd6;
    localparam logic [6:0] reg_info_local       = 7'd7;
    localparam logic [6:0] reg_info_buffer_size = 7'd8;

    localparam logic [3:0] breg_phy_x       = 4'd0;
    localparam logic [3:0] breg_phy_y       = 4'd1;
    localparam logic [3:0] breg_phy_local   = 4'd2;
    localparam logic [3:0] breg_msg_type    = 4'd3;  // tx on write, rx on read
    localparam logic [3:0] breg_instance_id = 4'd4;
    localparam logic [3:0] breg_type_id     = 4'd5;
    localparam logic [3:0] breg_data        = 4'd6;  // tx on write, rx on read
    localparam logic [3:0] breg_tx          = 4'd7;
    localparam logic [3:0] breg_rx          = 4'd8;

    localparam logic [wb_data_w-1:0] cmd_result_err = '1;

    localparam logic [2:0] msg_call      = 3'd0;
    localparam logic [2:0] msg_resp      = 3'd1;
    localparam logic [2:0] msg_call_data = 3'd2;
    localparam logic [2:0] msg_resp_data = 3'd3;
    localparam logic [2:0] msg_error     = 3'd4;

    //////////////////////////////
    // types
    //////////////////////////////
    typedef struct packed {
        logic [soc_size_x-1:0] x;
        logic [soc_size_y-1:0] y;
        logic [local_w-1:0]    loc;
    } noc_node_t;

    typedef struct packed {
        logic [7:0]  type_id;
        logic [7:0]  instance_id;
        logic [7:0]  msg_type;
        logic [31:0] payload;
    } noc_msg_t;

    typedef struct packed {
        noc_node_t src;
        noc_node_t dst;
        noc_msg_t  msg;
    } noc_flit_t;

    typedef struct packed {
        noc_node_t             dst;       // proxy node
        logic [2:0]            msg_type;
        logic [7:0]            instance_id;
        logic [7:0]            type_id;
        logic [wb_data_w-1:0]  data;
    } buf_cfg_t;

    typedef buf_cfg_t [buffer_size-1:0] buf_cfg_arr_t;

    typedef struct packed {
        logic [2:0]           msg_type;
        logic [wb_data_w-1:0] data;
    } buf_rx_t;

    typedef buf_rx_t [buffer_size-1:0] buf_rx_arr_t;

    // bit 7 picks control or buffer space
    typedef union packed {
        struct packed {
            logic       space;
            logic [6:0] ctrl_sel;
        } ctrl;
        struct packed {
            logic       space;
            logic [3:0] breg;
            logic [2:0] buf_sel;
        } bufr;
    } wb_addr_u;

endpackage
